//--- bench/adam_lite_tests.txt
# W/R addr be wdata exp_rdata exp_err, all hex; lower case w/r follow with no idle cycle
# C exp_unit_rst exp_unit_pause exp_boot_addr
C f 0 0100
W 0010 f 11223344 00000000 0
R 0010 0 00000000 11223344 0
W 0010 5 aabbccdd 00000000 0
R 0010 0 00000000 11bb33dd 0
W 0020 f 00000000 00000000 0
R 0020 0 00000000 00000000 0
W 1000 1 00000000 00000000 0
W 1004 1 00000002 00000000 0
W 1008 1 ffffff03 00000000 0
W 100c e 00000000 00000000 0
C c 6 0100
R 1008 0 00000000 00000003 0
R 100c 0 00000000 00000001 0
W 1010 1 0000abcd 00000000 0
C c 6 01cd
W 1010 2 0000ab00 00000000 0
R 1010 0 00000000 0000abcd 0
R 1014 0 00000000 00000000 0
W 0410 f deadbeef 00000000 1
R 2000 0 00000000 00000000 1
W 1020 1 00000000 00000000 1
C c 6 abcd
R 0010 0 00000000 11bb33dd 0
W 0030 f 01020304 00000000 0
w 0034 f 05060708 00000000 0
r 0030 0 00000000 01020304 0
r 0034 0 00000000 05060708 0
r 2000 0 00000000 00000000 1
r 1004 0 00000000 00000002 0
r 0010 0 00000000 11bb33dd 0

//--- files.f
design/adam_pkg.sv
design/adam_mem_if.sv
design/adam_bus_decode.sv
design/adam_mem.sv
design/adam_syscfg.sv
design/adam_resp_mux.sv
design/adam_lite.sv
bench/adam_lite_props.sv
bench/adam_lite_tb.sv

//--- Makefile
SRCS := $(shell cat files.f)

.PHONY: run clean

run: obj_dir/Vadam_lite_tb
	./obj_dir/Vadam_lite_tb

obj_dir/Vadam_lite_tb: files.f $(SRCS)
	verilator --binary --assert --top-module adam_lite_tb -f files.f -o Vadam_lite_tb

clean:
	rm -rf obj_dir

//--- bench/adam_lite_tb.sv
`default_nettype none
`timescale 1ns/1ps

module adam_lite_tb;
    import adam_pkg::*;

    logic       clk_i;
    logic       arst_n_i;
    logic       req_i;
    logic       we_i;
    addr_t      addr_i;
    strb_t      be_i;
    data_t      wdata_i;
    logic       rvalid_o;
    data_t      rdata_o;
    logic       err_o;
    unit_mask_t unit_rst_o;
    unit_mask_t unit_pause_o;
    addr_t      boot_addr_o;

    // expected result of the request in flight
    logic       pending;
    data_t      pend_data;
    logic       pend_err;

    adam_lite dut_i (.*);

    always #5 clk_i = ~clk_i;

    task automatic fail_run(string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_data(string name, data_t got, data_t exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_err(string name, logic got, logic exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_mask(string name, unit_mask_t got, unit_mask_t exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp));
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic drive(logic req, logic we, addr_t addr, strb_t be, data_t wdata);
        @(posedge clk_i);
        #1;
        req_i   = req;
        we_i    = we;
        addr_i  = addr;
        be_i    = be;
        wdata_i = wdata;
    endtask

    // sample mid-cycle once the registered results have settled
    task automatic collect();
        int waited;
        waited = 0;
        @(negedge clk_i);
        if (!pending) begin
            check_err("rvalid_o", rvalid_o, 1'b0);
            check_err("err_o", err_o, 1'b0);
        end else begin
            while (rvalid_o !== 1'b1) begin
                if (waited == 20) begin
                    fail_run("timeout: no rvalid_o within 20 cycles of a request");
                end else begin
                    waited++;
                    drive(1'b0, 1'b0, '0, '0, '0);
                    @(negedge clk_i);
                end
            end
            check_err("err_o", err_o, pend_err);
            check_data("rdata_o", rdata_o, pend_data);
            pending = 1'b0;
        end
    endtask

    task automatic idle_cycle();
        drive(1'b0, 1'b0, '0, '0, '0);
        collect();
    endtask

    initial begin
        int         fd;
        int         gap;
        int         nops;
        int         nfields;
        byte        op;
        string      line;
        string      args;
        addr_t      addr;
        strb_t      be;
        data_t      wdata;
        data_t      exp_data;
        logic       exp_err;
        unit_mask_t exp_rst;
        unit_mask_t exp_pause;
        addr_t      exp_boot;

        clk_i    = 1'b0;
        arst_n_i = 1'b0;
        req_i    = 1'b0;
        we_i     = 1'b0;
        addr_i   = '0;
        be_i     = '0;
        wdata_i  = '0;
        pending  = 1'b0;
        nops     = 0;
        void'($urandom(80059));

        repeat (5) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;

        fd = $fopen("bench/adam_lite_tests.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open bench/adam_lite_tests.txt");
        end
        while ($fgets(line, fd) > 0) begin
            op   = line[0];
            args = line.substr(2, line.len() - 1);
            if (op == "C") begin
                nfields = $sscanf(args, "%h %h %h", exp_rst, exp_pause, exp_boot);
                if (nfields != 3) begin
                    fail_run("malformed check line in the test file");
                end
                idle_cycle();
                check_mask("unit_rst_o", unit_rst_o, exp_rst);
                check_mask("unit_pause_o", unit_pause_o, exp_pause);
                check_addr("boot_addr_o", boot_addr_o, exp_boot);
                nops++;
            end else if (op == "W" || op == "w" || op == "R" || op == "r") begin
                nfields = $sscanf(args, "%h %h %h %h %h", addr, be, wdata, exp_data, exp_err);
                if (nfields != 5) begin
                    fail_run("malformed bus line in the test file");
                end
                // lower case ops follow the previous request with no gap
                gap = (op == "w" || op == "r") ? 0 : int'($urandom % 4);
                repeat (gap) idle_cycle();
                drive(1'b1, op == "W" || op == "w", addr, be, wdata);
                collect();
                pending   = 1'b1;
                pend_data = exp_data;
                pend_err  = exp_err;
                nops++;
            end
        end
        $fclose(fd);
        idle_cycle();
        if (nops == 0) begin
            fail_run("no operations found in bench/adam_lite_tests.txt");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- bench/adam_lite_props.sv
`default_nettype none
`timescale 1ns/1ps

module adam_lite_props (
    input logic            clk_i,
    input logic            arst_n_i,
    input logic            req_i,
    input logic            rvalid_i,
    input adam_pkg::data_t rdata_i,
    input logic            err_i
);

    // each request answered on the very next cycle
    req_answered: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        req_i |=> rvalid_i)
        else $error("rvalid_o missing one cycle after a request");

    // errors never carry data
    err_no_data: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        err_i |-> rdata_i == '0)
        else $error("err_o high with nonzero rdata_o");

    no_spurious_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rvalid_i |-> $past(req_i))
        else $error("rvalid_o without a request one cycle earlier");

endmodule

bind adam_lite adam_lite_props props_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (req_i),
    .rvalid_i (rvalid_o),
    .rdata_i  (rdata_o),
    .err_i    (err_o)
);

`default_nettype wire

//--- design/adam_lite.sv
`default_nettype none
`timescale 1ns/1ps

module adam_lite (
    input  logic clk_i,
    input  logic arst_n_i,

    // host strobe bus
    input  logic            req_i,
    input  logic            we_i,
    input  adam_pkg::addr_t addr_i,
    input  adam_pkg::strb_t be_i,
    input  adam_pkg::data_t wdata_i,

    output logic            rvalid_o,
    output adam_pkg::data_t rdata_o,
    output logic            err_o,

    // unit control levels
    output adam_pkg::unit_mask_t unit_rst_o,
    output adam_pkg::unit_mask_t unit_pause_o,
    output adam_pkg::addr_t      boot_addr_o
);
    import adam_pkg::*;

    adam_mem_if mem_bus ();
    adam_mem_if cfg_bus ();

    target_e target;

    adam_bus_decode i_decode (
        .req_i    (req_i),
        .we_i     (we_i),
        .addr_i   (addr_i),
        .be_i     (be_i),
        .wdata_i  (wdata_i),
        .target_o (target),
        .mem_o    (mem_bus),
        .cfg_o    (cfg_bus)
    );

    adam_mem i_mem (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .bus_i    (mem_bus)
    );

    adam_syscfg i_syscfg (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .bus_i        (cfg_bus),
        .unit_rst_o   (unit_rst_o),
        .unit_pause_o (unit_pause_o),
        .boot_addr_o  (boot_addr_o)
    );

    adam_resp_mux i_resp (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_i       (req_i),
        .we_i        (we_i),
        .target_i    (target),
        .mem_rdata_i (mem_bus.rdata),
        .cfg_rdata_i (cfg_bus.rdata),
        .rvalid_o    (rvalid_o),
        .rdata_o     (rdata_o),
        .err_o       (err_o)
    );

endmodule

`default_nettype wire

//--- design/adam_resp_mux.sv
`default_nettype none
`timescale 1ns/1ps

module adam_resp_mux (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              req_i,
    input  logic              we_i,
    input  adam_pkg::target_e target_i,
    input  adam_pkg::data_t   mem_rdata_i,
    input  adam_pkg::data_t   cfg_rdata_i,
    output logic              rvalid_o,
    output adam_pkg::data_t   rdata_o,
    output logic              err_o
);
    import adam_pkg::*;

    logic    req_q;
    logic    we_q;
    target_e target_q;

    // register each request and answer it one cycle later
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_q    <= 1'b0;
            we_q     <= 1'b0;
            target_q <= TGT_NONE;
        end else begin
            req_q    <= req_i;
            we_q     <= we_i;
            target_q <= target_i;
        end
    end

    assign rvalid_o = req_q;
    assign err_o    = req_q && (target_q == TGT_NONE);

    always_comb begin
        rdata_o = '0;
        if (req_q && !we_q) begin
            case (target_q)
                TGT_MEM: rdata_o = mem_rdata_i;
                TGT_CFG: rdata_o = cfg_rdata_i;
                default: rdata_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/adam_syscfg.sv
`default_nettype none
`timescale 1ns/1ps

module adam_syscfg (
    input  logic clk_i,
    input  logic arst_n_i,

    adam_mem_if.target bus_i,

    output adam_pkg::unit_mask_t unit_rst_o,
    output adam_pkg::unit_mask_t unit_pause_o,
    output adam_pkg::addr_t      boot_addr_o
);
    import adam_pkg::*;

    unit_mask_t unit_rst_q;
    unit_mask_t unit_pause_q;
    addr_t      boot_addr_q;

    addr_t      word_addr;
    unit_mask_t unit_sel;
    logic       boot_sel;
    data_t      rd_value;

    assign word_addr = {bus_i.addr[ADDR_WIDTH-1:2], 2'b00};
    assign boot_sel  = (word_addr == CFG_BOOT_OFFSET);

    // one control word per unit
    always_comb begin
        for (int i = 0; i < NO_UNITS; i++) begin
            unit_sel[i] = (word_addr == addr_t'(CFG_UNIT_OFFSET + 4 * i));
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            unit_rst_q   <= '1;
            unit_pause_q <= '0;
            boot_addr_q  <= BOOT_ADDR_RESET;
        end else if (bus_i.req && bus_i.we) begin
            for (int i = 0; i < NO_UNITS; i++) begin
                if (unit_sel[i] && bus_i.be[0]) begin
                    unit_rst_q[i]   <= bus_i.wdata[0];
                    unit_pause_q[i] <= bus_i.wdata[1];
                end
            end
            if (boot_sel && bus_i.be[0]) begin
                boot_addr_q[7:0] <= bus_i.wdata[7:0];
            end
            if (boot_sel && bus_i.be[1]) begin
                boot_addr_q[15:8] <= bus_i.wdata[15:8];
            end
        end
    end

    // holes in the map read as zero
    always_comb begin
        rd_value = '0;
        for (int i = 0; i < NO_UNITS; i++) begin
            if (unit_sel[i]) begin
                rd_value[1:0] = {unit_pause_q[i], unit_rst_q[i]};
            end
        end
        if (boot_sel) begin
            rd_value[ADDR_WIDTH-1:0] = boot_addr_q;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bus_i.rdata <= '0;
        end else begin
            bus_i.rdata <= (bus_i.req && !bus_i.we) ? rd_value : '0;
        end
    end

    assign unit_rst_o   = unit_rst_q;
    assign unit_pause_o = unit_pause_q;
    assign boot_addr_o  = boot_addr_q;

endmodule

`default_nettype wire

//--- design/adam_mem.sv
`default_nettype none
`timescale 1ns/1ps

module adam_mem (
    input logic clk_i,
    input logic arst_n_i,

    adam_mem_if.target bus_i
);
    import adam_pkg::*;

    data_t                    mem [MEM_WORDS];
    logic [MEM_IDX_WIDTH-1:0] idx;

    // word index from the window-relative byte address
    assign idx = bus_i.addr[MEM_IDX_WIDTH+1:2];

    always_ff @(posedge clk_i) begin
        if (bus_i.req && bus_i.we) begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (bus_i.be[b]) begin
                    mem[idx][8*b +: 8] <= bus_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // read port returns zero when no read was strobed
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bus_i.rdata <= '0;
        end else if (bus_i.req && !bus_i.we) begin
            bus_i.rdata <= mem[idx];
        end else begin
            bus_i.rdata <= '0;
        end
    end

endmodule

`default_nettype wire

//--- design/adam_bus_decode.sv
`default_nettype none
`timescale 1ns/1ps

module adam_bus_decode (
    input  logic              req_i,
    input  logic              we_i,
    input  adam_pkg::addr_t   addr_i,
    input  adam_pkg::strb_t   be_i,
    input  adam_pkg::data_t   wdata_i,
    output adam_pkg::target_e target_o,

    adam_mem_if.initiator mem_o,
    adam_mem_if.initiator cfg_o
);
    import adam_pkg::*;

    function automatic logic in_window(addr_t addr, addr_t base, addr_t limit);
        return (addr >= base) && (addr <= limit);
    endfunction

    logic mem_hit;
    logic cfg_hit;

    assign mem_hit = in_window(addr_i, MEM_BASE, MEM_LIMIT);
    assign cfg_hit = in_window(addr_i, CFG_BASE, CFG_LIMIT);

    always_comb begin
        if (mem_hit) begin
            target_o = TGT_MEM;
        end else if (cfg_hit) begin
            target_o = TGT_CFG;
        end else begin
            target_o = TGT_NONE;
        end
    end

    // unmapped accesses strobe neither target
    assign mem_o.req   = req_i && (target_o == TGT_MEM);
    assign mem_o.we    = we_i;
    assign mem_o.addr  = addr_i - MEM_BASE;
    assign mem_o.be    = be_i;
    assign mem_o.wdata = wdata_i;

    assign cfg_o.req   = req_i && (target_o == TGT_CFG);
    assign cfg_o.we    = we_i;
    assign cfg_o.addr  = addr_i - CFG_BASE;
    assign cfg_o.be    = be_i;
    assign cfg_o.wdata = wdata_i;

endmodule

`default_nettype wire

//--- design/adam_mem_if.sv
`default_nettype none
`timescale 1ns/1ps

interface adam_mem_if;
    import adam_pkg::*;

    logic  req;
    logic  we;
    addr_t addr;
    strb_t be;
    data_t wdata;
    data_t rdata;

    // decoder side
    modport initiator (output req, we, addr, be, wdata, input rdata);

    // memory or register side
    modport target (input req, we, addr, be, wdata, output rdata);

endinterface

`default_nettype wire

//--- design/adam_pkg.sv
`default_nettype none

package adam_pkg;

    // bus widths
    localparam int unsigned ADDR_WIDTH = 16;
    localparam int unsigned DATA_WIDTH = 32;
    localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;

    // local word memory
    localparam int unsigned MEM_WORDS     = 256;
    localparam int unsigned MEM_IDX_WIDTH = $clog2(MEM_WORDS);

    // one reset and one pause bit for each controlled unit
    localparam int unsigned NO_UNITS = 4;

    typedef logic [NO_UNITS-1:0] unit_mask_t;

    // address map as inclusive byte windows
    localparam addr_t MEM_BASE  = 16'h0000;
    localparam addr_t MEM_LIMIT = 16'h03FF;
    localparam addr_t CFG_BASE  = 16'h1000;
    localparam addr_t CFG_LIMIT = 16'h101F;

    // register offsets inside the configuration window
    localparam addr_t CFG_UNIT_OFFSET = 16'h0000;
    localparam addr_t CFG_BOOT_OFFSET = 16'h0010;

    localparam addr_t BOOT_ADDR_RESET = 16'h0100;

    typedef enum logic [1:0] {
        TGT_MEM,
        TGT_CFG,
        TGT_NONE
    } target_e;

endpackage

`default_nettype wire
